//--- common/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // data and address width
    localparam int word_width = 32;

    ////////////////////////////////////////
    // request kinds
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        kind_load  = 2'd0,
        kind_store = 2'd1,
        kind_cacop = 2'd2
    } req_kind_t;

    ////////////////////////////////////////
    // controller states
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        st_idle        = 4'd0,
        // tag compare of the buffered request
        st_lookup      = 4'd1,
        // line read request, waiting for addr_ok
        st_miss_r      = 4'd2,
        st_miss_r_wait = 4'd3,
        // store miss goes straight to memory
        st_miss_w      = 4'd4,
        st_hit_w       = 4'd5,
        st_hit_w_resp  = 4'd6,
        st_cacop       = 4'd7
    } ctrl_state_t;

endpackage

//--- dcache/dcache_req_buf.sv
`timescale 1ns/1ps

module dcache_req_buf import dcache_pkg::*; #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    we,
    input  req_kind_t               req_kind,
    input  logic [word_width-1:0]   req_addr,
    input  logic [word_width-1:0]   req_wdata,
    input  logic [3:0]              req_wstrb,
    output req_kind_t               buf_kind,
    output logic [word_width-1:0]   buf_addr,
    output logic [word_width-1:0]   buf_wdata,
    output logic [3:0]              buf_wstrb
);

    localparam int tag_width = word_width - index_width - offset_width - 2;

    // address kept as fields, byte offset dropped
    logic [tag_width-1:0]       tag_q;
    logic [index_width-1:0]     index_q;
    logic [offset_width-1:0]    offset_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_kind  <= kind_load;
            tag_q     <= '0;
            index_q   <= '0;
            offset_q  <= '0;
            buf_wdata <= '0;
            buf_wstrb <= '0;
        end else if (we) begin
            buf_kind  <= req_kind;
            tag_q     <= req_addr[word_width-1 -: tag_width];
            index_q   <= req_addr[offset_width+2 +: index_width];
            offset_q  <= req_addr[2 +: offset_width];
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    // word address of the held request
    assign buf_addr = {tag_q, index_q, offset_q, 2'b00};

endmodule

//--- dcache/dcache_lru.sv
`timescale 1ns/1ps

module dcache_lru #(
    parameter int index_width = 4
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [index_width-1:0]  index,
    input  logic                    use_en,
    input  logic                    use_way,
    output logic                    victim
);

    localparam int sets = 1 << index_width;

    // one bit per set, names the older way
    logic [sets-1:0] lru_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use_en) begin
            lru_q[index] <= ~use_way;
        end
    end

    assign victim = lru_q[index];

endmodule

//--- dcache/dcache_store.sv
`timescale 1ns/1ps

module dcache_store import dcache_pkg::*; #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic [word_width-1:0]                 req_addr,
    input  logic [word_width-1:0]                 buf_addr,
    input  logic [word_width-1:0]                 buf_wdata,
    input  logic [3:0]                            buf_wstrb,
    input  logic [1:0]                            data_we,
    input  logic                                  refill,
    input  logic                                  inval,
    input  logic                                  sel_return,
    input  logic [(word_width<<offset_width)-1:0] mem_rline,
    output logic [1:0]                            hit,
    output logic [word_width-1:0]                 rdata
);

    localparam int tag_width  = word_width - index_width - offset_width - 2;
    localparam int sets       = 1 << index_width;
    localparam int line_width = word_width << offset_width;

    logic [tag_width-1:0]       buf_tag;
    logic [index_width-1:0]     buf_idx;
    logic [offset_width-1:0]    buf_off;
    logic [index_width-1:0]     req_idx;
    logic [offset_width-1:0]    req_off;

    logic [tag_width-1:0]   tag_arr  [2][sets];
    logic [line_width-1:0]  data_arr [2][sets];
    logic [1:0]             valid_q  [sets];

    logic [word_width-1:0]  rd_word_q   [2];
    logic [line_width-1:0]  merged_line [2];
    logic [word_width-1:0]  refill_word;

    assign buf_tag = buf_addr[word_width-1 -: tag_width];
    assign buf_idx = buf_addr[offset_width+2 +: index_width];
    assign buf_off = buf_addr[2 +: offset_width];
    assign req_idx = req_addr[offset_width+2 +: index_width];
    assign req_off = req_addr[2 +: offset_width];

    ////////////////////////////////////////
    // tag compare at the buffered index
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid_q[buf_idx][w] && (tag_arr[w][buf_idx] == buf_tag);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= 2'b00;
            end
        end else if (inval) begin
            // cacop drops both ways of the set
            valid_q[buf_idx] <= 2'b00;
        end else if (refill) begin
            for (int w = 0; w < 2; w++) begin
                if (data_we[w]) begin
                    valid_q[buf_idx][w] <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // data arrays
    ////////////////////////////////////////

    // store hit, merge strobed bytes into the held line
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            merged_line[w] = data_arr[w][buf_idx];
            for (int b = 0; b < 4; b++) begin
                if (buf_wstrb[b]) begin
                    merged_line[w][buf_off*word_width + b*8 +: 8] = buf_wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (data_we[w]) begin
                data_arr[w][buf_idx] <= refill ? mem_rline : merged_line[w];
                if (refill) begin
                    tag_arr[w][buf_idx] <= buf_tag;
                end
            end
        end
    end

    // read at the incoming index, used one cycle later in lookup
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            rd_word_q[w] <= data_arr[w][req_idx][req_off*word_width +: word_width];
        end
    end

    assign refill_word = mem_rline[buf_off*word_width +: word_width];
    assign rdata       = sel_return ? refill_word : (hit[1] ? rd_word_q[1] : rd_word_q[0]);

    // a line lives in at most one way
    assert property (@(posedge clk) disable iff (!rstn) !(&hit))
        else $error("tag hit in both ways at index %0d", buf_idx);

endmodule

//--- dcache/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req_valid,
    input  req_kind_t   req_kind,
    output logic        req_ready,
    output logic        rbuf_we,
    input  req_kind_t   buf_kind,
    input  logic [1:0]  hit,
    input  logic        victim,
    output logic [1:0]  data_we,
    output logic        refill,
    output logic        inval,
    output logic        sel_return,
    output logic        use_en,
    output logic        use_way,
    output logic        resp_valid,
    output logic        mem_req,
    output logic        mem_wr,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    input  logic        mem_bvalid
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    ctrl_state_t accept_state;

    // where a newly accepted request goes
    assign accept_state = !req_valid              ? st_idle  :
                          (req_kind == kind_cacop) ? st_cacop : st_lookup;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                next_state = accept_state;
            end
            st_lookup: begin
                if (hit == 2'b00) begin
                    if (buf_kind == kind_store) begin
                        // store miss may finish here
                        next_state = mem_addr_ok ? accept_state : st_miss_w;
                    end else begin
                        next_state = mem_addr_ok ? st_miss_r_wait : st_miss_r;
                    end
                end else if (buf_kind == kind_store) begin
                    next_state = mem_addr_ok ? st_hit_w_resp : st_hit_w;
                end else begin
                    next_state = accept_state;
                end
            end
            st_miss_r: begin
                if (mem_addr_ok) begin
                    next_state = st_miss_r_wait;
                end
            end
            st_miss_r_wait: begin
                // refill owns the arrays this cycle so nothing is accepted
                if (mem_data_ok) begin
                    next_state = st_idle;
                end
            end
            st_miss_w: begin
                if (mem_addr_ok) begin
                    next_state = accept_state;
                end
            end
            st_hit_w: begin
                if (mem_addr_ok) begin
                    next_state = st_hit_w_resp;
                end
            end
            st_hit_w_resp: begin
                if (mem_bvalid) begin
                    next_state = accept_state;
                end
            end
            st_cacop: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    ////////////////////////////////////////
    // outputs from state and next state
    ////////////////////////////////////////

    always_comb begin
        req_ready  = 1'b0;
        rbuf_we    = 1'b0;
        data_we    = 2'b00;
        refill     = 1'b0;
        inval      = 1'b0;
        sel_return = 1'b0;
        use_en     = 1'b0;
        use_way    = hit[1];
        resp_valid = 1'b0;
        mem_req    = 1'b0;
        mem_wr     = 1'b0;
        case (state)
            st_idle: begin
                req_ready = 1'b1;
                rbuf_we   = req_valid;
            end
            st_lookup: begin
                case (next_state)
                    st_miss_r, st_miss_r_wait: begin
                        mem_req = 1'b1;
                    end
                    st_miss_w: begin
                        mem_req = 1'b1;
                        mem_wr  = 1'b1;
                    end
                    st_hit_w, st_hit_w_resp: begin
                        // write the hit way and memory together
                        mem_req = 1'b1;
                        mem_wr  = 1'b1;
                        data_we = hit;
                        use_en  = 1'b1;
                    end
                    default: begin
                        req_ready = 1'b1;
                        rbuf_we   = req_valid;
                        if (hit != 2'b00) begin
                            resp_valid = 1'b1;
                            use_en     = 1'b1;
                        end else begin
                            // store miss taken on the first try
                            mem_req = 1'b1;
                            mem_wr  = 1'b1;
                        end
                    end
                endcase
            end
            st_miss_r: begin
                mem_req = 1'b1;
            end
            st_miss_r_wait: begin
                if (next_state != st_miss_r_wait) begin
                    refill          = 1'b1;
                    sel_return      = 1'b1;
                    resp_valid      = 1'b1;
                    use_en          = 1'b1;
                    use_way         = victim;
                    data_we[victim] = 1'b1;
                end
            end
            st_miss_w: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (next_state != st_miss_w) begin
                    req_ready = 1'b1;
                    rbuf_we   = req_valid;
                end
            end
            st_hit_w: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
            end
            st_hit_w_resp: begin
                if (next_state != st_hit_w_resp) begin
                    req_ready = 1'b1;
                    rbuf_we   = req_valid;
                end
            end
            st_cacop: begin
                inval = 1'b1;
            end
            default: begin
                req_ready = 1'b0;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstn) !(&data_we))
        else $error("both ways written in state %s", state.name());

    // request and direction hold until the address is taken
    assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && (mem_wr == $past(mem_wr)))
        else $error("memory request changed before addr_ok in state %s", state.name());

endmodule

//--- design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                                  clk,
    input  logic                                  rstn,

    // pipeline side
    input  logic                                  req_valid,
    input  req_kind_t                             req_kind,
    input  logic [word_width-1:0]                 req_addr,
    input  logic [word_width-1:0]                 req_wdata,
    input  logic [3:0]                            req_wstrb,
    output logic                                  req_ready,
    output logic                                  resp_valid,
    output logic [word_width-1:0]                 resp_rdata,

    // memory side
    output logic                                  mem_req,
    output logic                                  mem_wr,
    output logic [word_width-1:0]                 mem_addr,
    output logic [word_width-1:0]                 mem_wdata,
    output logic [3:0]                            mem_wstrb,
    input  logic                                  mem_addr_ok,
    input  logic                                  mem_data_ok,
    input  logic [(word_width<<offset_width)-1:0] mem_rline,
    input  logic                                  mem_bvalid
);

    logic                   rbuf_we;
    req_kind_t              buf_kind;
    logic [word_width-1:0]  buf_addr;
    logic [word_width-1:0]  buf_wdata;
    logic [3:0]             buf_wstrb;
    logic [1:0]             hit;
    logic [1:0]             data_we;
    logic                   refill;
    logic                   inval;
    logic                   sel_return;
    logic                   use_en;
    logic                   use_way;
    logic                   victim;

    dcache_req_buf #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_req_buf (
        .clk       (clk),
        .rstn      (rstn),
        .we        (rbuf_we),
        .req_kind  (req_kind),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .buf_kind  (buf_kind),
        .buf_addr  (buf_addr),
        .buf_wdata (buf_wdata),
        .buf_wstrb (buf_wstrb)
    );

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_kind    (req_kind),
        .req_ready   (req_ready),
        .rbuf_we     (rbuf_we),
        .buf_kind    (buf_kind),
        .hit         (hit),
        .victim      (victim),
        .data_we     (data_we),
        .refill      (refill),
        .inval       (inval),
        .sel_return  (sel_return),
        .use_en      (use_en),
        .use_way     (use_way),
        .resp_valid  (resp_valid),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_bvalid  (mem_bvalid)
    );

    dcache_store #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_store (
        .clk        (clk),
        .rstn       (rstn),
        .req_addr   (req_addr),
        .buf_addr   (buf_addr),
        .buf_wdata  (buf_wdata),
        .buf_wstrb  (buf_wstrb),
        .data_we    (data_we),
        .refill     (refill),
        .inval      (inval),
        .sel_return (sel_return),
        .mem_rline  (mem_rline),
        .hit        (hit),
        .rdata      (resp_rdata)
    );

    dcache_lru #(
        .index_width (index_width)
    ) u_lru (
        .clk     (clk),
        .rstn    (rstn),
        .index   (buf_addr[offset_width+2 +: index_width]),
        .use_en  (use_en),
        .use_way (use_way),
        .victim  (victim)
    );

    // line reads go out aligned, writes keep the word address
    assign mem_addr  = mem_wr ? buf_addr :
                       {buf_addr[word_width-1:offset_width+2], {(offset_width+2){1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

endmodule

//--- verif/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter int offset_width = 2
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          mem_req,
    input  logic                          mem_wr,
    input  logic [31:0]                   mem_addr,
    input  logic [31:0]                   mem_wdata,
    input  logic [3:0]                    mem_wstrb,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [(32<<offset_width)-1:0] rline,
    output logic                          bvalid,
    output int                            read_count,
    output int                            write_count
);

    localparam int words = 1 << offset_width;

    logic [31:0] mem [1024];
    logic [9:0]  idx_q;
    logic        wr_q;
    logic [1:0]  phase;
    int          wait_cnt;
    integer      seed = 32'hfe06c042;

    // preset depends on every address bit
    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000 ^ i;
        end
    end

    // phase 0 wait for req, 1 addr_ok cycle, 2 response delay, 3 response cycle
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_ok     <= 1'b0;
            data_ok     <= 1'b0;
            bvalid      <= 1'b0;
            rline       <= '0;
            phase       <= 2'd0;
            wait_cnt    <= 0;
            idx_q       <= '0;
            wr_q        <= 1'b0;
            read_count  <= 0;
            write_count <= 0;
        end else begin
            addr_ok <= 1'b0;
            data_ok <= 1'b0;
            bvalid  <= 1'b0;
            case (phase)
                2'd0: begin
                    if (mem_req && wait_cnt == 0) begin
                        addr_ok  <= 1'b1;
                        idx_q    <= mem_addr[11:2];
                        wr_q     <= mem_wr;
                        wait_cnt <= $unsigned($random(seed)) % 4;
                        phase    <= 2'd1;
                        if (mem_wr) begin
                            write_count <= write_count + 1;
                            for (int b = 0; b < 4; b++) begin
                                if (mem_wstrb[b]) begin
                                    mem[mem_addr[11:2]][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                                end
                            end
                        end else begin
                            read_count <= read_count + 1;
                        end
                    end else if (mem_req) begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                2'd1: begin
                    phase <= 2'd2;
                end
                2'd2: begin
                    if (wait_cnt == 0) begin
                        if (wr_q) begin
                            bvalid <= 1'b1;
                        end else begin
                            data_ok <= 1'b1;
                            for (int w = 0; w < words; w++) begin
                                rline[w*32 +: 32] <= mem[idx_q + w];
                            end
                        end
                        wait_cnt <= $unsigned($random(seed)) % 4;
                        phase    <= 2'd3;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                default: begin
                    phase <= 2'd0;
                end
            endcase
        end
    end

endmodule

//--- verif/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*;;

    localparam int max_entries = 64;
    localparam int limit       = 200;

    logic                 clk;
    logic                 rstn;
    logic                 req_valid;
    req_kind_t            req_kind;
    logic [31:0]          req_addr;
    logic [31:0]          req_wdata;
    logic [3:0]           req_wstrb;
    logic                 req_ready;
    logic                 resp_valid;
    logic [31:0]          resp_rdata;
    logic                 mem_req;
    logic                 mem_wr;
    logic [31:0]          mem_addr;
    logic [31:0]          mem_wdata;
    logic [3:0]           mem_wstrb;
    logic                 mem_addr_ok;
    logic                 mem_data_ok;
    logic [127:0]         mem_rline;
    logic                 mem_bvalid;
    int                   read_count;
    int                   write_count;

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    req_kind_t   t_kind   [max_entries];
    logic [31:0] t_addr   [max_entries];
    logic [31:0] t_wdata  [max_entries];
    logic [3:0]  t_wstrb  [max_entries];
    // expected load data or memory word after a store
    logic [31:0] t_exp    [max_entries];
    // expected read count increase or -1 when not known
    int          t_reads  [max_entries];
    int          t_test   [max_entries];
    int          n_entries;

    logic [31:0] ref_mem  [1024];
    string       test_name [7];
    int          checks;
    int          errors;
    int          test_errs;
    logic        timed_out;
    integer      seed = 32'hfe06c042;

    dcache_top #(
        .index_width  (4),
        .offset_width (2)
    ) UUT (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_kind    (req_kind),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rline   (mem_rline),
        .mem_bvalid  (mem_bvalid)
    );

    mem_model #(
        .offset_width (2)
    ) u_mem (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .addr_ok     (mem_addr_ok),
        .data_ok     (mem_data_ok),
        .rline       (mem_rline),
        .bvalid      (mem_bvalid),
        .read_count  (read_count),
        .write_count (write_count)
    );

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors    = errors + 1;
            test_errs = test_errs + 1;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic flag_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
        errors    = errors + 1;
        test_errs = test_errs + 1;
    endtask

    task automatic add_entry(input int test, input req_kind_t kind, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             input int reads);
        logic [31:0] word;
        word = ref_mem[addr[11:2]];
        // reference applies store bytes in program order
        if (kind == kind_store) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    word[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            ref_mem[addr[11:2]] = word;
        end
        t_kind[n_entries]  = kind;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_wstrb[n_entries] = wstrb;
        t_exp[n_entries]   = word;
        t_reads[n_entries] = reads;
        t_test[n_entries]  = test;
        n_entries = n_entries + 1;
    endtask

    task automatic wait_ready();
        int cnt;
        cnt = 0;
        while (!req_ready && !timed_out) begin
            @(negedge clk);
            cnt = cnt + 1;
            if (cnt > limit) begin
                flag_timeout("req_ready");
            end
        end
    endtask

    task automatic run_entry(input int i);
        int reads0;
        int writes0;
        int cnt;
        reads0    = read_count;
        writes0   = write_count;
        req_valid = 1'b1;
        req_kind  = t_kind[i];
        req_addr  = t_addr[i];
        req_wdata = t_wdata[i];
        req_wstrb = t_wstrb[i];
        wait_ready();
        if (timed_out) begin
            return;
        end
        @(negedge clk);
        req_valid = 1'b0;
        if (t_kind[i] == kind_load) begin
            cnt = 0;
            while (!resp_valid && !timed_out) begin
                @(negedge clk);
                cnt = cnt + 1;
                if (cnt > limit) begin
                    flag_timeout("load response");
                end
            end
            if (timed_out) begin
                return;
            end
            check("resp_rdata", resp_rdata, t_exp[i]);
        end else begin
            @(negedge clk);
            wait_ready();
            if (timed_out) begin
                return;
            end
            if (t_kind[i] == kind_store) begin
                check("mem word", u_mem.mem[t_addr[i][11:2]], t_exp[i]);
                check("write count delta", 32'(write_count - writes0), 32'd1);
            end
        end
        if (t_reads[i] >= 0) begin
            check("read count delta", 32'(read_count - reads0), 32'(t_reads[i]));
        end
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_kind  = kind_load;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        timed_out = 1'b0;
        n_entries = 0;
        test_name[1] = "load miss then hit";
        test_name[2] = "store hit merge";
        test_name[3] = "store miss";
        test_name[4] = "lru replacement";
        test_name[5] = "cacop invalidate";
        test_name[6] = "random mix";
        #1;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = u_mem.mem[i];
        end

        add_entry(1, kind_load, 32'h040, 32'h0, 4'h0, 1);
        add_entry(1, kind_load, 32'h044, 32'h0, 4'h0, 0);
        add_entry(2, kind_store, 32'h040, 32'haabbccdd, 4'b0101, 0);
        add_entry(2, kind_load, 32'h040, 32'h0, 4'h0, 0);
        add_entry(3, kind_store, 32'h300, 32'h12345678, 4'hf, 0);
        add_entry(3, kind_load, 32'h300, 32'h0, 4'h0, 1);
        // a, b and c all map to set 1
        add_entry(4, kind_load, 32'h010, 32'h0, 4'h0, 1);
        add_entry(4, kind_load, 32'h110, 32'h0, 4'h0, 1);
        add_entry(4, kind_load, 32'h010, 32'h0, 4'h0, 0);
        add_entry(4, kind_load, 32'h210, 32'h0, 4'h0, 1);
        add_entry(4, kind_load, 32'h010, 32'h0, 4'h0, 0);
        add_entry(4, kind_load, 32'h110, 32'h0, 4'h0, 1);
        add_entry(5, kind_cacop, 32'h010, 32'h0, 4'h0, 0);
        add_entry(5, kind_load, 32'h014, 32'h0, 4'h0, 1);
        add_entry(5, kind_load, 32'h118, 32'h0, 4'h0, 1);
        for (int k = 0; k < 30; k++) begin
            if ($random(seed) & 1) begin
                add_entry(6, kind_store, ($unsigned($random(seed)) % 256) << 2,
                          $random(seed), 4'(($unsigned($random(seed)) % 15) + 1), 0);
            end else begin
                add_entry(6, kind_load, ($unsigned($random(seed)) % 256) << 2,
                          32'h0, 4'h0, -1);
            end
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        ////////////////////////////////////////
        // apply the table
        ////////////////////////////////////////

        for (int i = 0; i < n_entries && !timed_out; i++) begin
            run_entry(i);
            if (timed_out || i == n_entries - 1 || t_test[i+1] != t_test[i]) begin
                $display("test %0d %s: %s", t_test[i], test_name[t_test[i]],
                         (test_errs == 0) ? "pass" : "fail");
                test_errs = 0;
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/dcache_pkg.sv
dcache/dcache_req_buf.sv
dcache/dcache_lru.sv
dcache/dcache_store.sv
dcache/dcache_ctrl.sv
design/dcache_top.sv
verif/mem_model.sv
verif/tb_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_dcache \
    --Mdir obj_dir -o tb_dcache > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_dcache > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0
